//--- hdl/bus_cmp_pkg.sv
// Bus compare package
// Widths, depths and beat types shared by the stream taps, the per-ID
// beat FIFOs and the pairwise comparator
package bus_cmp_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------
    localparam int unsigned ID_WIDTH   = 2;
    localparam int unsigned NUM_IDS    = 1 << ID_WIDTH;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned FIFO_DEPTH = 4;

    // Stored beat is last, data, id from top to bottom
    localparam int unsigned BEAT_WIDTH = 1 + DATA_WIDTH + ID_WIDTH;

    // FIFO bookkeeping
    localparam int unsigned PTR_WIDTH  = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_WIDTH  = PTR_WIDTH + 1;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------
    typedef logic [ID_WIDTH-1:0]   id_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BEAT_WIDTH-1:0] beat_t;

    // One bit per ID, for push, full, pop and mismatch vectors
    typedef logic [NUM_IDS-1:0]    id_mask_t;

    typedef logic [PTR_WIDTH-1:0]  ptr_t;
    typedef logic [CNT_WIDTH-1:0]  cnt_t;

endpackage

//--- hdl/stream_tap.sv
// Stream tap
// Passes one monitored valid/ready stream through to its downstream port
// and forks a copy of every beat into the FIFO selected by the beat's ID.
// Upstream is released only once both branches have taken the beat.
`timescale 1ns/1ns

module stream_tap
    import bus_cmp_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    // Upstream
    input  logic     valid_i,
    input  id_t      id_i,
    input  data_t    data_i,
    input  logic     last_i,
    output logic     ready_o,
    // Downstream
    output logic     valid_o,
    output id_t      id_o,
    output data_t    data_o,
    output logic     last_o,
    input  logic     ready_i,
    // Per-ID FIFOs of this side
    output id_mask_t push_o,
    output beat_t    beat_o,
    input  id_mask_t full_i
);

    // Bit 0 is the downstream branch, bit 1 the FIFO branch
    logic [1:0] taken_q;
    logic       ds_take;
    logic       fifo_take;
    logic       ds_done;
    logic       fifo_done;

    // ----------------------------------------------------------
    // Downstream branch
    // ----------------------------------------------------------
    // Payload is a straight copy with zero latency
    assign id_o    = id_i;
    assign data_o  = data_i;
    assign last_o  = last_i;
    assign valid_o = valid_i & ~taken_q[0];
    assign ds_take = valid_o & ready_i;

    // ----------------------------------------------------------
    // FIFO branch
    // ----------------------------------------------------------
    assign beat_o    = {last_i, data_i, id_i};
    assign fifo_take = valid_i & ~taken_q[1] & ~full_i[id_i];

    // Steer the push to the FIFO of the beat's ID
    always_comb begin
        push_o       = '0;
        push_o[id_i] = fifo_take;
    end

    // ----------------------------------------------------------
    // Fork handshake
    // ----------------------------------------------------------
    // Each branch either took the beat earlier or takes it now
    assign ds_done   = taken_q[0] | ready_i;
    assign fifo_done = taken_q[1] | ~full_i[id_i];
    assign ready_o   = ds_done & fifo_done;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            taken_q <= '0;
        end else if (valid_i && ready_o) begin
            // Start fresh once the beat is fully delivered
            taken_q <= '0;
        end else begin
            taken_q <= taken_q | {fifo_take, ds_take};
        end
    end

    // Upstream keeps its beat until released
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i && !ready_o |=> valid_i && $stable({id_i, data_i, last_i}))
        else $error("stream_tap: upstream beat changed before handshake");

endmodule

//--- hdl/beat_fifo.sv
// Beat FIFO
// Holds the beats of one ID on one side in arrival order until the
// comparator pops them. Circular buffer that is not fall-through, so a
// pushed beat shows at the head one cycle after the push.
`timescale 1ns/1ns

module beat_fifo
    import bus_cmp_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    // Write side
    input  logic  push_i,
    input  beat_t beat_i,
    output logic  full_o,
    // Read side
    input  logic  pop_i,
    output beat_t head_o,
    output logic  nonempty_o
);

    beat_t mem_q [FIFO_DEPTH];
    ptr_t  wr_ptr_q;
    ptr_t  rd_ptr_q;
    cnt_t  cnt_q;

    // ----------------------------------------------------------
    // Status and head
    // ----------------------------------------------------------
    assign full_o     = (cnt_q == cnt_t'(FIFO_DEPTH));
    assign nonempty_o = (cnt_q != '0);
    assign head_o     = mem_q[rd_ptr_q];

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= beat_i;
        end
    end

    // ----------------------------------------------------------
    // Pointers and fill count
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // The tap must hold off while full, the comparator must wait for data
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i && full_o |-> pop_i)
        else $error("beat_fifo: push into full FIFO");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> nonempty_o)
        else $error("beat_fifo: pop from empty FIFO");

endmodule

//--- hdl/beat_compare.sv
// Beat comparator
// For each ID, pops the A and B FIFO heads together as soon as both are
// present and flags a mismatch in that cycle if data or last differ.
// Also derives the general mismatch and the busy flag. Purely combinational.
`timescale 1ns/1ns

module beat_compare
    import bus_cmp_pkg::*;
(
    // FIFO heads, one per ID and side
    input  beat_t    head_a_i [NUM_IDS],
    input  beat_t    head_b_i [NUM_IDS],
    input  id_mask_t nonempty_a_i,
    input  id_mask_t nonempty_b_i,
    // Shared pop for the A and B FIFO of each ID
    output id_mask_t pop_o,
    // Results
    output id_mask_t id_mismatch_o,
    output logic     mismatch_o,
    output logic     busy_o
);

    // ----------------------------------------------------------
    // Per-ID pairing
    // ----------------------------------------------------------
    for (genvar id = 0; id < NUM_IDS; id++) begin : gen_cmp
        data_t data_a;
        data_t data_b;
        logic  last_a;
        logic  last_b;
        logic  pair_valid;
        logic  differ;

        // Unpack the heads; the ID field is equal by construction
        assign data_a = head_a_i[id][ID_WIDTH +: DATA_WIDTH];
        assign data_b = head_b_i[id][ID_WIDTH +: DATA_WIDTH];
        assign last_a = head_a_i[id][BEAT_WIDTH-1];
        assign last_b = head_b_i[id][BEAT_WIDTH-1];

        // Both sides hold a beat for this ID
        assign pair_valid = nonempty_a_i[id] & nonempty_b_i[id];
        assign differ     = (data_a != data_b) | (last_a != last_b);

        assign pop_o[id]         = pair_valid;
        assign id_mismatch_o[id] = pair_valid & differ;
    end

    // ----------------------------------------------------------
    // Summary flags
    // ----------------------------------------------------------
    assign mismatch_o = |id_mismatch_o;

    // Any stored beat still waits for its partner
    assign busy_o = (|nonempty_a_i) | (|nonempty_b_i);

endmodule

//--- hdl/bus_cmp_top.sv
// Bus compare top level
// Checks that two valid/ready response streams carry the same traffic.
// Each side passes through unchanged while a tap copies every beat into
// a per-ID FIFO; the comparator pairs the oldest beats of each ID.
`timescale 1ns/1ns

module bus_cmp_top
    import bus_cmp_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    // Side A upstream
    input  logic     a_valid_i,
    input  id_t      a_id_i,
    input  data_t    a_data_i,
    input  logic     a_last_i,
    output logic     a_ready_o,
    // Side A downstream
    output logic     a_valid_o,
    output id_t      a_id_o,
    output data_t    a_data_o,
    output logic     a_last_o,
    input  logic     a_ready_i,
    // Side B upstream
    input  logic     b_valid_i,
    input  id_t      b_id_i,
    input  data_t    b_data_i,
    input  logic     b_last_i,
    output logic     b_ready_o,
    // Side B downstream
    output logic     b_valid_o,
    output id_t      b_id_o,
    output data_t    b_data_o,
    output logic     b_last_o,
    input  logic     b_ready_i,
    // Results
    output id_mask_t id_mismatch_o,
    output logic     mismatch_o,
    output logic     busy_o
);

    // Tap to FIFO
    id_mask_t push_a;
    id_mask_t push_b;
    beat_t    beat_a;
    beat_t    beat_b;
    id_mask_t full_a;
    id_mask_t full_b;

    // FIFO to comparator
    beat_t    head_a [NUM_IDS];
    beat_t    head_b [NUM_IDS];
    id_mask_t nonempty_a;
    id_mask_t nonempty_b;
    id_mask_t pop;

    // ----------------------------------------------------------
    // Side A
    // ----------------------------------------------------------
    stream_tap i_tap_a (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .valid_i ( a_valid_i ),
        .id_i    ( a_id_i    ),
        .data_i  ( a_data_i  ),
        .last_i  ( a_last_i  ),
        .ready_o ( a_ready_o ),
        .valid_o ( a_valid_o ),
        .id_o    ( a_id_o    ),
        .data_o  ( a_data_o  ),
        .last_o  ( a_last_o  ),
        .ready_i ( a_ready_i ),
        .push_o  ( push_a    ),
        .beat_o  ( beat_a    ),
        .full_i  ( full_a    )
    );

    for (genvar id = 0; id < NUM_IDS; id++) begin : gen_fifos_a
        beat_fifo i_fifo (
            .clk_i      ( clk_i          ),
            .rst_ni     ( rst_ni         ),
            .push_i     ( push_a[id]     ),
            .beat_i     ( beat_a         ),
            .full_o     ( full_a[id]     ),
            .pop_i      ( pop[id]        ),
            .head_o     ( head_a[id]     ),
            .nonempty_o ( nonempty_a[id] )
        );
    end

    // ----------------------------------------------------------
    // Side B
    // ----------------------------------------------------------
    stream_tap i_tap_b (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .valid_i ( b_valid_i ),
        .id_i    ( b_id_i    ),
        .data_i  ( b_data_i  ),
        .last_i  ( b_last_i  ),
        .ready_o ( b_ready_o ),
        .valid_o ( b_valid_o ),
        .id_o    ( b_id_o    ),
        .data_o  ( b_data_o  ),
        .last_o  ( b_last_o  ),
        .ready_i ( b_ready_i ),
        .push_o  ( push_b    ),
        .beat_o  ( beat_b    ),
        .full_i  ( full_b    )
    );

    for (genvar id = 0; id < NUM_IDS; id++) begin : gen_fifos_b
        beat_fifo i_fifo (
            .clk_i      ( clk_i          ),
            .rst_ni     ( rst_ni         ),
            .push_i     ( push_b[id]     ),
            .beat_i     ( beat_b         ),
            .full_o     ( full_b[id]     ),
            .pop_i      ( pop[id]        ),
            .head_o     ( head_b[id]     ),
            .nonempty_o ( nonempty_b[id] )
        );
    end

    // ----------------------------------------------------------
    // Comparison
    // ----------------------------------------------------------
    beat_compare i_compare (
        .head_a_i      ( head_a        ),
        .head_b_i      ( head_b        ),
        .nonempty_a_i  ( nonempty_a    ),
        .nonempty_b_i  ( nonempty_b    ),
        .pop_o         ( pop           ),
        .id_mismatch_o ( id_mismatch_o ),
        .mismatch_o    ( mismatch_o    ),
        .busy_o        ( busy_o        )
    );

endmodule

//--- tb/tb_bus_cmp_model.svh
// Reference model for the bus compare testbench
// Per-side queues of beats still to send and beats still expected
// downstream, per-ID mismatch counts, and the compare tasks
`ifndef TB_BUS_CMP_MODEL_SVH
`define TB_BUS_CMP_MODEL_SVH

// Beats waiting to be driven upstream
beat_t src_a [$];
beat_t src_b [$];

// Beats expected on the downstream ports, in send order
beat_t exp_a [$];
beat_t exp_b [$];

// Corrupted pairs per ID, and mismatch pulses seen per ID
int exp_mis  [NUM_IDS];
int seen_mis [NUM_IDS];

int mis_errs;
int other_errs;

task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
        mis_errs++;
        $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_mask(input string name, input id_mask_t exp, input id_mask_t act);
    if (act !== exp) begin
        mis_errs++;
        $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        mis_errs++;
        $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        mis_errs++;
        $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic report_failure(input string what);
    other_errs++;
    $display("Error: %s", what);
endtask

`endif

//--- tb/tb_bus_cmp.sv
// Bus compare testbench
// Sends the same paired traffic on both sides with random gaps and
// downstream stalls, corrupts some B beats, and checks pass-through,
// per-ID mismatch pulses, back-pressure and drain against a model
`timescale 1ns/1ns

module tb_bus_cmp
    import bus_cmp_pkg::*;
();

    localparam logic [31:0] LFSR_SEED  = 32'h209ddc3b;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
    localparam int NUM_PAIRS      = 300;
    localparam int CLEAN_PAIRS    = 40;
    localparam int BP_PAIRS       = 5;
    localparam int RAND_PAIRS     = NUM_PAIRS - CLEAN_PAIRS - BP_PAIRS;
    localparam int DBIT_WIDTH     = $clog2(DATA_WIDTH);
    localparam int TIMEOUT_CYCLES = NUM_PAIRS * 2 * 20;

    logic     clk_i;
    logic     rst_ni;
    logic     a_valid_i, a_last_i, a_ready_o, a_valid_o, a_last_o, a_ready_i;
    logic     b_valid_i, b_last_i, b_ready_o, b_valid_o, b_last_o, b_ready_i;
    id_t      a_id_i, a_id_o, b_id_i, b_id_o;
    data_t    a_data_i, a_data_o, b_data_i, b_data_o;
    id_mask_t id_mismatch_o;
    logic     mismatch_o;
    logic     busy_o;

    // Testbench state
    logic [31:0] lfsr;
    logic        a_fire;
    logic        b_fire;
    bit          clean_phase;
    bit          drain_phase;
    bit          hold_b;
    int unsigned acc_a;
    int          cycle_cnt;

    `include "tb_bus_cmp_model.svh"

    bus_cmp_top i_bus_cmp_top (
        .clk_i, .rst_ni,
        .a_valid_i, .a_id_i, .a_data_i, .a_last_i, .a_ready_o,
        .a_valid_o, .a_id_o, .a_data_o, .a_last_o, .a_ready_i,
        .b_valid_i, .b_id_i, .b_data_i, .b_last_i, .b_ready_o,
        .b_valid_o, .b_id_o, .b_data_o, .b_last_o, .b_ready_i,
        .id_mismatch_o, .mismatch_o, .busy_o
    );

    always #20 clk_i = ~clk_i;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // Queue n pairs on both sides; some B copies get one bit flipped
    task automatic gen_pairs(input int n, input bit clean, input bit fixed, input id_t fixed_id);
        id_t         id;
        data_t       data;
        logic        last;
        beat_t       beat_a;
        beat_t       beat_b;
        int unsigned bit_idx;
        for (int i = 0; i < n; i++) begin
            id     = fixed ? fixed_id : id_t'(rand_bits(ID_WIDTH));
            data   = data_t'(rand_bits(DATA_WIDTH));
            last   = rand_bits(1) == 1;
            beat_a = {last, data, id};
            beat_b = beat_a;
            if (!clean && rand_bits(2) == 0) begin
                if (rand_bits(1) == 1) begin
                    beat_b[BEAT_WIDTH-1] = ~beat_b[BEAT_WIDTH-1];
                end else begin
                    bit_idx = rand_bits(DBIT_WIDTH);
                    beat_b  = beat_b ^ (beat_t'(1) << (ID_WIDTH + bit_idx));
                end
                exp_mis[id]++;
            end
            src_a.push_back(beat_a);
            src_b.push_back(beat_b);
            exp_a.push_back(beat_a);
            exp_b.push_back(beat_b);
        end
    endtask

    // Everything sent, delivered downstream and compared
    task automatic wait_drain();
        do begin
            @(negedge clk_i);
        end while (src_a.size() != 0 || src_b.size() != 0 || exp_a.size() != 0 ||
                   exp_b.size() != 0 || a_valid_i || b_valid_i || busy_o);
    endtask

    // ------------------------------------------------------------
    // Upstream and downstream drivers
    // ------------------------------------------------------------
    initial begin
        beat_t next_beat;
        acc_a     = 0;
        a_valid_i <= 1'b0;
        a_id_i    <= '0;
        a_data_i  <= '0;
        a_last_i  <= 1'b0;
        a_ready_i <= 1'b0;
        b_valid_i <= 1'b0;
        b_id_i    <= '0;
        b_data_i  <= '0;
        b_last_i  <= 1'b0;
        b_ready_i <= 1'b0;
        forever begin
            @(posedge clk_i);
            if (rst_ni) begin
                if (!a_valid_i || a_fire) begin
                    if (a_fire) begin
                        acc_a++;
                    end
                    if (src_a.size() != 0 && rand_bits(2) != 0) begin
                        next_beat = src_a.pop_front();
                        a_valid_i <= 1'b1;
                        a_id_i    <= next_beat[ID_WIDTH-1:0];
                        a_data_i  <= next_beat[ID_WIDTH +: DATA_WIDTH];
                        a_last_i  <= next_beat[BEAT_WIDTH-1];
                    end else begin
                        a_valid_i <= 1'b0;
                    end
                end
                if (!b_valid_i || b_fire) begin
                    if (!hold_b && src_b.size() != 0 && rand_bits(2) != 0) begin
                        next_beat = src_b.pop_front();
                        b_valid_i <= 1'b1;
                        b_id_i    <= next_beat[ID_WIDTH-1:0];
                        b_data_i  <= next_beat[ID_WIDTH +: DATA_WIDTH];
                        b_last_i  <= next_beat[BEAT_WIDTH-1];
                    end else begin
                        b_valid_i <= 1'b0;
                    end
                end
                // Downstream ready about 75%
                a_ready_i <= (rand_bits(2) != 0);
                b_ready_i <= (rand_bits(2) != 0);
            end
        end
    end

    // ------------------------------------------------------------
    // Monitor sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni) begin
            a_fire = a_valid_i && a_ready_o;
            b_fire = b_valid_i && b_ready_o;
            if (a_valid_o && a_ready_i) begin
                if (exp_a.size() == 0) begin
                    report_failure("side A delivered a beat that was never sent");
                end else begin
                    check_beat("pass-through A", exp_a.pop_front(), {a_last_o, a_data_o, a_id_o});
                end
            end
            if (b_valid_o && b_ready_i) begin
                if (exp_b.size() == 0) begin
                    report_failure("side B delivered a beat that was never sent");
                end else begin
                    check_beat("pass-through B", exp_b.pop_front(), {b_last_o, b_data_o, b_id_o});
                end
            end
            for (int i = 0; i < NUM_IDS; i++) begin
                if (id_mismatch_o[id_t'(i)]) begin
                    seen_mis[id_t'(i)]++;
                end
            end
            check_flag("mismatch_o vs OR of ID bits", |id_mismatch_o, mismatch_o);
            if (clean_phase && mismatch_o) begin
                report_failure("mismatch_o rose while only clean pairs were sent");
            end
            if (drain_phase && busy_o) begin
                report_failure("busy_o went high after all traffic drained");
            end
        end else begin
            a_fire = 1'b0;
            b_fire = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int unsigned base;
        id_mask_t    exp_any;
        id_mask_t    seen_any;
        clk_i       = 1'b0;
        lfsr        = LFSR_SEED;
        clean_phase = 1'b0;
        drain_phase = 1'b0;
        hold_b      = 1'b0;
        rst_ni      <= 1'b0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        check_flag("reset a_valid_o", 1'b0, a_valid_o);
        check_flag("reset b_valid_o", 1'b0, b_valid_o);
        check_flag("reset mismatch_o", 1'b0, mismatch_o);
        check_flag("reset busy_o", 1'b0, busy_o);
        check_mask("reset id_mismatch_o", '0, id_mismatch_o);

        // Clean prefix with no alarms allowed
        clean_phase = 1'b1;
        gen_pairs(CLEAN_PAIRS, 1'b1, 1'b0, '0);
        wait_drain();
        clean_phase = 1'b0;

        // Side A runs ahead on one ID until its FIFO fills
        hold_b = 1'b1;
        base   = acc_a;
        gen_pairs(BP_PAIRS, 1'b0, 1'b1, id_t'(2));
        do begin
            @(negedge clk_i);
        end while (acc_a < base + FIFO_DEPTH);
        repeat (8) begin
            @(negedge clk_i);
            check_flag("back-pressure a_ready_o", 1'b0, a_ready_o);
            // Idle side B with empty FIFOs follows its downstream ready
            check_flag("idle b_ready_o", b_ready_i, b_ready_o);
        end
        hold_b = 1'b0;
        wait_drain();

        // Random traffic with corruption
        gen_pairs(RAND_PAIRS, 1'b0, 1'b0, '0);
        wait_drain();
        drain_phase = 1'b1;
        repeat (10) @(negedge clk_i);
        drain_phase = 1'b0;

        for (int i = 0; i < NUM_IDS; i++) begin
            check_count($sformatf("mismatch count of ID %0d", i),
                        exp_mis[id_t'(i)], seen_mis[id_t'(i)]);
            exp_any[id_t'(i)]  = (exp_mis[id_t'(i)] != 0);
            seen_any[id_t'(i)] = (seen_mis[id_t'(i)] != 0);
        end
        check_mask("IDs with mismatches", exp_any, seen_any);

        $display("Checks done: %0d value mismatches, %0d other errors", mis_errs, other_errs);
        if (mis_errs == 0 && other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Run limit of 20 cycles per beat per side
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: traffic did not drain");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+tb
hdl/bus_cmp_pkg.sv
hdl/stream_tap.sv
hdl/beat_fifo.sv
hdl/beat_compare.sv
hdl/bus_cmp_top.sv
tb/tb_bus_cmp.sv

//--- run.sh
#!/bin/sh
# Compile and run the bus compare testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_bus_cmp -o sim_tb_bus_cmp \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb_bus_cmp > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
